//--- pipeCore.f
verilog/pipePkg.sv
verilog/pipeIf.sv
verilog/fetchUnit.sv
verilog/decodeStage.sv
verilog/idExReg.sv
verilog/executeStage.sv
verilog/pipeCore.sv
bench/pipeCore_properties.sv
bench/pipeCoreTb.sv

//--- run.sh
#!/bin/sh
# Build and run the pipeCore testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module pipeCoreTb -f pipeCore.f

# A failing run exits nonzero, the log search below decides the result
./obj_dir/VpipeCoreTb > sim.log 2>&1 || true
cat sim.log

if grep -qx "test passed" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

//--- bench/pipeCore_testdata.txt
# W lines hold instruction words in hex stored from address 0 upward
# E lines hold an expected retire register and value in hex and P ends a program
W 2001FFFF  addi r1, r0, 0xffff
W 34028001  ori  r2, r0, 0x8001
W 00221820  add  r3, r1, r2
W 00612022  sub  r4, r3, r1
W 0024282A  slt  r5, r1, r4
W 3C068765  lui  r6, 0x8765
W 28C70001  slti r7, r6, 1
W 38C8FFFF  xori r8, r6, 0xffff
W 30298F0F  andi r9, r1, 0x8f0f
W FC000000  halt
W 200A0005  addi r10, r0, 5 sits behind halt
E 01 FFFFFFFF
E 02 00008001
E 03 00008000
E 04 00008001
E 05 00000001
E 06 87650000
E 07 00000001
E 08 8765FFFF
E 09 00008F0F
P
W 20001234  addi r0, r0, 0x1234
W 00005820  add  r11, r0, r0
W 296C8000  slti r12, r11, 0x8000
W FC000000  halt
E 0B 00000000
E 0C 00000000
P

//--- bench/pipeCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module pipeCoreTb import pipePkg::*; ();

    logic                 Clk;
    logic                 rst;
    logic                 loadReq;
    logic [ImemAddrW-1:0] loadAddr;
    logic [Xlen-1:0]      loadWord;
    logic                 loadAck;
    logic                 start;
    logic                 retireValid;
    logic [RegAddrW-1:0]  retireReg;
    logic [Xlen-1:0]      retireData;
    logic                 done;

    // Programs and traces of all records back to back
    logic [Xlen-1:0]     progWords [$];
    logic [RegAddrW-1:0] expReg [$];
    logic [Xlen-1:0]     expData [$];
    int                  wordCount [$];
    int                  writeCount [$];

    logic [31:0] lcgState;
    int          timeoutCycles;
    bit          failPrinted;
    bit          runPassed;

    pipeCore pipeCore_i (
        .Clk         (Clk),
        .rst         (rst),
        .loadReq     (loadReq),
        .loadAddr    (loadAddr),
        .loadWord    (loadWord),
        .loadAck     (loadAck),
        .start       (start),
        .retireValid (retireValid),
        .retireReg   (retireReg),
        .retireData  (retireData),
        .done        (done)
    );

    // 8 ns clock
    initial begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic abortRun(input string reason);
        failPrinted = 1'b1;
        $display("%s", reason);
        $display("test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    function automatic int nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return int'(lcgState[30:16]);
    endfunction

    task automatic checkReg(input string name, input logic [RegAddrW-1:0] got,
                            input logic [RegAddrW-1:0] exp);
        if (got !== exp) begin
            abortRun($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic checkData(input string name, input logic [Xlen-1:0] got,
                             input logic [Xlen-1:0] exp);
        if (got !== exp) begin
            abortRun($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic checkCount(input string name, input int got, input int exp);
        if (got != exp) begin
            abortRun($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic readTestData();
        int              fd;
        int              n;
        int              words;
        int              writes;
        string           line;
        byte             tag;
        logic [Xlen-1:0] a;
        logic [Xlen-1:0] b;
        fd = $fopen("bench/pipeCore_testdata.txt", "r");
        if (fd == 0) begin
            abortRun("Could not open bench/pipeCore_testdata.txt");
        end
        words  = 0;
        writes = 0;
        while ($fgets(line, fd) > 0) begin
            tag = line.getc(0);
            if (tag == "W") begin
                n = $sscanf(line.substr(1, line.len() - 1), "%h", a);
                if (n != 1) begin
                    abortRun("Malformed program word record in the test data");
                end
                progWords.push_back(a);
                words++;
            end else if (tag == "E") begin
                n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
                if (n != 2) begin
                    abortRun("Malformed expected trace record in the test data");
                end
                expReg.push_back(a[RegAddrW-1:0]);
                expData.push_back(b);
                writes++;
            end else if (tag == "P") begin
                wordCount.push_back(words);
                writeCount.push_back(writes);
                words  = 0;
                writes = 0;
            end
        end
        $fclose(fd);
        // 20 cycles per loaded word plus 10 per executed instruction
        timeoutCycles = 20 * progWords.size() + 10 * progWords.size();
    endtask

    task automatic resetCore();
        @(posedge Clk);
        rst <= 1'b1;
        repeat (10) @(posedge Clk);
        rst <= 1'b0;
        @(posedge Clk);
        if (loadAck || retireValid || done) begin
            abortRun("Outputs were not cleared by reset");
        end
    endtask

    // One four-phase transfer after a random idle gap
    task automatic loadWordAt(input logic [ImemAddrW-1:0] addr, input logic [Xlen-1:0] word);
        repeat (nextRand() % 4) @(posedge Clk);
        loadAddr <= addr;
        loadWord <= word;
        loadReq  <= 1'b1;
        @(posedge Clk);
        while (!loadAck) @(posedge Clk);
        loadReq <= 1'b0;
        @(posedge Clk);
        while (loadAck) @(posedge Clk);
    endtask

    task automatic collectTrace(input int first, input int count);
        int seen;
        seen = 0;
        @(posedge Clk);
        while (!done) begin
            if (retireValid) begin
                if (seen >= count) begin
                    abortRun("More register writes retired than the trace expects");
                end
                checkReg("retireReg", retireReg, expReg[first + seen]);
                checkData("retireData", retireData, expData[first + seen]);
                seen++;
            end
            @(posedge Clk);
        end
        checkCount("trace length", seen, count);
        // Nothing behind HALT may retire, and done must hold
        repeat (8) begin
            if (retireValid) begin
                abortRun("An instruction behind HALT retired");
            end
            if (!done) begin
                abortRun("done fell before reset");
            end
            @(posedge Clk);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int wordBase;
        int expBase;
        rst      <= 1'b1;
        loadReq  <= 1'b0;
        loadAddr <= '0;
        loadWord <= '0;
        start    <= 1'b0;
        lcgState = 32'd34216;
        readTestData();
        wordBase = 0;
        expBase  = 0;
        for (int p = 0; p < wordCount.size(); p++) begin
            resetCore();
            for (int w = 0; w < wordCount[p]; w++) begin
                loadWordAt(ImemAddrW'(w), progWords[wordBase + w]);
            end
            start <= 1'b1;
            @(posedge Clk);
            start <= 1'b0;
            collectTrace(expBase, writeCount[p]);
            wordBase += wordCount[p];
            expBase  += writeCount[p];
        end
        runPassed = 1'b1;
        $display("test passed");
        $finish;
    end

    initial begin
        wait (timeoutCycles > 0);
        repeat (timeoutCycles) @(posedge Clk);
        abortRun($sformatf("Run timed out after %0d cycles", timeoutCycles));
    end

    final begin
        if (!runPassed && !failPrinted) begin
            $display("test failed");
        end
    end

endmodule

`default_nettype wire

//--- bench/pipeCore_properties.sv
`timescale 1ns/1ps
`default_nettype none

module pipeCore_properties import pipePkg::*; (
    input wire logic                Clk,
    input wire logic                rst,
    input wire logic                loadReq,
    input wire logic                loadAck,
    input wire logic                retireValid,
    input wire logic [RegAddrW-1:0] retireReg,
    input wire logic                done
);

    ////////////////////////////////////////////////////////////////////////////
    // Load handshake
    ////////////////////////////////////////////////////////////////////////////

    ackFollowsReq: assert property (@(posedge Clk) disable iff (rst)
        $rose(loadAck) |-> $past(loadReq))
        else $error("loadAck rose without a pending loadReq");

    // Ack may only drop once the request is gone
    ackHeldWhileReq: assert property (@(posedge Clk) disable iff (rst)
        $fell(loadAck) |-> !$past(loadReq))
        else $error("loadAck fell while loadReq was still high");

    ////////////////////////////////////////////////////////////////////////////
    // Retire port
    ////////////////////////////////////////////////////////////////////////////

    noRetireToZero: assert property (@(posedge Clk) disable iff (rst)
        retireValid |-> retireReg != '0)
        else $error("retire write to register 0");

    doneHolds: assert property (@(posedge Clk) $fell(done) |-> $past(rst))
        else $error("done fell without reset");

endmodule

bind pipeCore pipeCore_properties pipeCore_properties_i (
    .Clk         (Clk),
    .rst         (rst),
    .loadReq     (loadReq),
    .loadAck     (loadAck),
    .retireValid (retireValid),
    .retireReg   (retireReg),
    .done        (done)
);

`default_nettype wire

//--- verilog/pipeCore.sv
`timescale 1ns/1ps
`default_nettype none

module pipeCore import pipePkg::*; (
    input  wire logic                 Clk,
    input  wire logic                 rst,
    input  wire logic                 loadReq,
    input  wire logic [ImemAddrW-1:0] loadAddr,
    input  wire logic [Xlen-1:0]      loadWord,
    output logic                      loadAck,
    input  wire logic                 start,
    output logic                      retireValid,
    output logic [RegAddrW-1:0]       retireReg,
    output logic [Xlen-1:0]           retireData,
    output logic                      done
);

    logic [Xlen-1:0] instruction;
    logic            fetchValid;
    logic            haltSeen;

    // Decode to stage register, stage register to execute
    idExBus dBus ();
    idExBus eBus ();

    fetchUnit fetchUnit_i (
        .Clk         (Clk),
        .rst         (rst),
        .loadReq     (loadReq),
        .loadAddr    (loadAddr),
        .loadWord    (loadWord),
        .loadAck     (loadAck),
        .start       (start),
        .haltSeen    (haltSeen),
        .instruction (instruction),
        .fetchValid  (fetchValid)
    );

    decodeStage decodeStage_i (
        .Clk         (Clk),
        .rst         (rst),
        .instruction (instruction),
        .fetchValid  (fetchValid),
        .wbValid     (retireValid),
        .wbReg       (retireReg),
        .wbData      (retireData),
        .haltSeen    (haltSeen),
        .dBus        (dBus.source)
    );

    idExReg idExReg_i (
        .Clk      (Clk),
        .rst      (rst),
        .haltSeen (haltSeen),
        .dBus     (dBus.sink),
        .eBus     (eBus.source)
    );

    executeStage executeStage_i (
        .Clk         (Clk),
        .rst         (rst),
        .eBus        (eBus.sink),
        .retireValid (retireValid),
        .retireReg   (retireReg),
        .retireData  (retireData),
        .done        (done)
    );

endmodule

`default_nettype wire

//--- verilog/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage import pipePkg::*; (
    input  wire logic            Clk,
    input  wire logic            rst,
    idExBus.sink                 eBus,
    output logic                 retireValid,
    output logic [RegAddrW-1:0]  retireReg,
    output logic [Xlen-1:0]      retireData,
    output logic                 done
);

    logic [Xlen-1:0] opA;
    logic [Xlen-1:0] rtFwd;
    logic [Xlen-1:0] opB;
    logic [Xlen-1:0] aluResult;
    logic            sltBit;

    ////////////////////////////////////////////////////////////////////////////
    // Operand forwarding from EX/WB
    ////////////////////////////////////////////////////////////////////////////

    // retireValid already implies a valid, register-writing instruction
    assign opA   = (retireValid && retireReg == eBus.rs) ? retireData : eBus.rsData;
    assign rtFwd = (retireValid && retireReg == eBus.rt) ? retireData : eBus.rtData;
    assign opB   = eBus.aluSrc ? eBus.imm : rtFwd;

    ////////////////////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////////////////////

    assign sltBit = $signed(opA) < $signed(opB);

    always_comb begin
        case (eBus.aluOp)
            aluAdd:  aluResult = opA + opB;
            aluSub:  aluResult = opA - opB;
            aluAnd:  aluResult = opA & opB;
            aluOr:   aluResult = opA | opB;
            aluXor:  aluResult = opA ^ opB;
            aluSlt:  aluResult = {{(Xlen-1){1'b0}}, sltBit};
            aluLui:  aluResult = eBus.imm << 16;
            default: aluResult = '0;
        endcase
    end

    // EX/WB register, also the retire port
    always_ff @(posedge Clk) begin
        if (rst) begin
            retireValid <= 1'b0;
            retireReg   <= '0;
            retireData  <= '0;
            done        <= 1'b0;
        end else begin
            retireValid <= eBus.valid && eBus.regWrite;
            retireReg   <= eBus.rd;
            retireData  <= aluResult;
            if (eBus.valid && eBus.halt) begin
                done <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/idExReg.sv
`timescale 1ns/1ps
`default_nettype none

module idExReg import pipePkg::*; (
    input  wire logic Clk,
    input  wire logic rst,
    input  wire logic haltSeen,
    idExBus.sink      dBus,
    idExBus.source    eBus
);

    always_ff @(posedge Clk) begin
        if (rst) begin
            eBus.valid    <= 1'b0;
            eBus.regWrite <= 1'b0;
            eBus.aluSrc   <= 1'b0;
            eBus.aluOp    <= aluAdd;
            eBus.halt     <= 1'b0;
            eBus.rs       <= '0;
            eBus.rt       <= '0;
            eBus.rd       <= '0;
            eBus.rsData   <= '0;
            eBus.rtData   <= '0;
            eBus.imm      <= '0;
        end else if (haltSeen) begin
            // Bubble behind the HALT
            eBus.valid    <= 1'b0;
            eBus.regWrite <= 1'b0;
            eBus.halt     <= 1'b0;
        end else begin
            eBus.valid    <= dBus.valid;
            eBus.regWrite <= dBus.regWrite;
            eBus.aluSrc   <= dBus.aluSrc;
            eBus.aluOp    <= dBus.aluOp;
            eBus.halt     <= dBus.halt;
            eBus.rs       <= dBus.rs;
            eBus.rt       <= dBus.rt;
            eBus.rd       <= dBus.rd;
            eBus.rsData   <= dBus.rsData;
            eBus.rtData   <= dBus.rtData;
            eBus.imm      <= dBus.imm;
        end
    end

endmodule

`default_nettype wire

//--- verilog/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage import pipePkg::*; (
    input  wire logic                Clk,
    input  wire logic                rst,
    input  wire logic [Xlen-1:0]     instruction,
    input  wire logic                fetchValid,
    input  wire logic                wbValid,
    input  wire logic [RegAddrW-1:0] wbReg,
    input  wire logic [Xlen-1:0]     wbData,
    output logic                     haltSeen,
    idExBus.source                   dBus
);

    opcodeT              opcode;
    functT               funct;
    logic [RegAddrW-1:0] rs;
    logic [RegAddrW-1:0] rt;
    logic [RegAddrW-1:0] rd;
    logic [15:0]         imm16;
    logic [Xlen-1:0]     regFile [RegCount];

    logic                regWrite;
    logic                aluSrc;
    aluOpT               aluOp;
    logic                zeroExt;
    logic                isHalt;
    logic [RegAddrW-1:0] destReg;

    // Instruction fields
    assign opcode = opcodeT'(instruction[31:26]);
    assign rs     = instruction[25:21];
    assign rt     = instruction[20:16];
    assign rd     = instruction[15:11];
    assign funct  = functT'(instruction[5:0]);
    assign imm16  = instruction[15:0];

    ////////////////////////////////////////////////////////////////////////////
    // Control decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        regWrite = 1'b0;
        aluSrc   = 1'b1;
        aluOp    = aluAdd;
        zeroExt  = 1'b0;
        isHalt   = 1'b0;
        destReg  = rt;
        case (opcode)
            opRtype: begin
                aluSrc   = 1'b0;
                destReg  = rd;
                regWrite = 1'b1;
                case (funct)
                    fnAdd: aluOp = aluAdd;
                    fnSub: aluOp = aluSub;
                    fnAnd: aluOp = aluAnd;
                    fnOr:  aluOp = aluOr;
                    fnXor: aluOp = aluXor;
                    fnSlt: aluOp = aluSlt;
                    // Unknown function, no-op
                    default: regWrite = 1'b0;
                endcase
            end
            opAddi: regWrite = 1'b1;
            opSlti: begin
                regWrite = 1'b1;
                aluOp    = aluSlt;
            end
            opAndi: begin
                regWrite = 1'b1;
                aluOp    = aluAnd;
                zeroExt  = 1'b1;
            end
            opOri: begin
                regWrite = 1'b1;
                aluOp    = aluOr;
                zeroExt  = 1'b1;
            end
            opXori: begin
                regWrite = 1'b1;
                aluOp    = aluXor;
                zeroExt  = 1'b1;
            end
            opLui: begin
                regWrite = 1'b1;
                aluOp    = aluLui;
                zeroExt  = 1'b1;
            end
            opHalt: isHalt = 1'b1;
            default: regWrite = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Register file
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (wbValid) begin
            regFile[wbReg] <= wbData;
        end
    end

    // Reads see a same-cycle write; r0 always reads zero
    always_comb begin
        if (rs == '0) dBus.rsData = '0;
        else if (wbValid && wbReg == rs) dBus.rsData = wbData;
        else dBus.rsData = regFile[rs];

        if (rt == '0) dBus.rtData = '0;
        else if (wbValid && wbReg == rt) dBus.rtData = wbData;
        else dBus.rtData = regFile[rt];
    end

    assign dBus.valid    = fetchValid;
    assign dBus.regWrite = regWrite && (destReg != '0);
    assign dBus.aluSrc   = aluSrc;
    assign dBus.aluOp    = aluOp;
    assign dBus.halt     = isHalt;
    assign dBus.rs       = rs;
    assign dBus.rt       = rt;
    assign dBus.rd       = destReg;
    assign dBus.imm      = zeroExt ? {{(Xlen-16){1'b0}}, imm16} : {{(Xlen-16){imm16[15]}}, imm16};

    always_ff @(posedge Clk) begin
        if (rst) begin
            haltSeen <= 1'b0;
        end else if (fetchValid && isHalt) begin
            haltSeen <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/fetchUnit.sv
`timescale 1ns/1ps
`default_nettype none

module fetchUnit import pipePkg::*; (
    input  wire logic                 Clk,
    input  wire logic                 rst,
    input  wire logic                 loadReq,
    input  wire logic [ImemAddrW-1:0] loadAddr,
    input  wire logic [Xlen-1:0]      loadWord,
    output logic                      loadAck,
    input  wire logic                 start,
    input  wire logic                 haltSeen,
    output logic [Xlen-1:0]           instruction,
    output logic                      fetchValid
);

    typedef enum logic {idle, acked} loadStateT;

    loadStateT           loadState;
    logic [Xlen-1:0]     imem [ImemDepth];
    logic [ImemAddrW-1:0] pc;
    logic                running;

    ////////////////////////////////////////////////////////////////////////////
    // Program load, four-phase req/ack
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (rst) begin
            loadState <= idle;
        end else begin
            case (loadState)
                idle: if (loadReq && !running) loadState <= acked;
                acked: if (!loadReq) loadState <= idle;
                default: loadState <= idle;
            endcase
        end
    end

    // Word is captured together with the ack
    always_ff @(posedge Clk) begin
        if (loadState == idle && loadReq && !running) begin
            imem[loadAddr] <= loadWord;
        end
    end

    assign loadAck = (loadState == acked);

    ////////////////////////////////////////////////////////////////////////////
    // Program counter and fetch register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (rst) begin
            running     <= 1'b0;
            pc          <= '0;
            instruction <= '0;
            fetchValid  <= 1'b0;
        end else if (start) begin
            // First word goes out on the start edge
            running     <= 1'b1;
            pc          <= ImemAddrW'(1);
            instruction <= imem[0];
            fetchValid  <= 1'b1;
        end else if (haltSeen) begin
            running    <= 1'b0;
            fetchValid <= 1'b0;
        end else if (running) begin
            pc          <= pc + 1'b1;
            instruction <= imem[pc];
            fetchValid  <= 1'b1;
        end else begin
            fetchValid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/pipeIf.sv
`timescale 1ns/1ps
`default_nettype none

// One decoded instruction on its way to execute
interface idExBus import pipePkg::*; ();

    logic                valid;
    logic                regWrite;
    logic                aluSrc;
    aluOpT               aluOp;
    logic                halt;
    logic [RegAddrW-1:0] rs;
    logic [RegAddrW-1:0] rt;
    logic [RegAddrW-1:0] rd;
    logic [Xlen-1:0]     rsData;
    logic [Xlen-1:0]     rtData;
    logic [Xlen-1:0]     imm;

    modport source (output valid, regWrite, aluSrc, aluOp, halt,
                    output rs, rt, rd, rsData, rtData, imm);

    modport sink (input valid, regWrite, aluSrc, aluOp, halt,
                  input rs, rt, rd, rsData, rtData, imm);

endinterface

`default_nettype wire

//--- verilog/pipePkg.sv
`default_nettype none

package pipePkg;

    // Datapath and instruction width
    localparam int Xlen = 32;

    // Register file geometry
    localparam int RegAddrW = 5;
    localparam int RegCount = 1 << RegAddrW;

    // Instruction memory geometry
    localparam int ImemDepth = 64;
    localparam int ImemAddrW = 6;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction encodings
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [5:0] {
        opRtype = 6'h00,
        opAddi  = 6'h08,
        opSlti  = 6'h0A,
        opAndi  = 6'h0C,
        opOri   = 6'h0D,
        opXori  = 6'h0E,
        opLui   = 6'h0F,
        opHalt  = 6'h3F
    } opcodeT;

    // R-type function field
    typedef enum logic [5:0] {
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnXor = 6'h26,
        fnSlt = 6'h2A
    } functT;

    // Operation selected for the ALU in execute
    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluLui
    } aluOpT;

endpackage

`default_nettype wire
